//--- hdl/shell_defines.svh
/*
 * Stream widths, port codes and reset hold length shared by the DMA
 * attachment RTL and its testbench. Include wherever a macro is needed.
 */
`ifndef SHELL_DEFINES_SVH
`define SHELL_DEFINES_SVH

// stream widths
`define SHELL_TDATA_W 64
`define SHELL_TKEEP_W 8
// only the low 32 bits of the metadata carry fields
`define SHELL_TUSER_W 128

// one-hot port codes as seen in the src/dst bytes
`define SHELL_PORT_QDMA0 8'd2
`define SHELL_PORT_QDMA1 8'd8

// cycles the pipeline stays in reset after axis_rst drops
`define SHELL_RST_HOLD 16

`endif

//--- hdl/shell_pkg.sv
/*
 * Types shared by the host DMA attachment: the stream beat, its metadata
 * word, the port byte decode and the c2h packet state and queue codes.
 */
`default_nettype none

`include "shell_defines.svh"

package shell_pkg;

  // one port byte, read as a raw code or as per-port flags
  typedef union packed {
    logic [7:0] code;
    struct packed {
      logic [3:0] spare;
      logic       qdma1;
      logic       cmac1;
      logic       qdma0;
      logic       cmac0;
    } flags;
  } port_flags_u;

  // metadata word, size in the low bits
  typedef struct packed {
    logic [`SHELL_TUSER_W-33:0] rsvd;
    port_flags_u                dst;
    port_flags_u                src;
    logic [15:0]                size;
  } pkt_meta_t;

  typedef struct packed {
    logic [`SHELL_TDATA_W-1:0] tdata;
    logic [`SHELL_TKEEP_W-1:0] tkeep;
    logic                      tlast;
    pkt_meta_t                 tuser;
  } axis_beat_t;

  typedef enum logic {
    IDLE = 1'b0,
    PKT  = 1'b1
  } c2h_state_e;

  // destination codes expected by the host queues
  typedef enum logic [15:0] {
    QDMA_DST_Q0 = 16'd1,
    QDMA_DST_Q1 = 16'd2
  } qdma_dst_e;

endpackage

`default_nettype wire

//--- hdl/rst_hold_counter.sv
/*
 * Keeps the pipeline in reset for a fixed number of cycles once the
 * external axis_rst is released. pipe_rst feeds all stream logic.
 */
`timescale 1ns/1ps
`default_nettype none

`include "shell_defines.svh"

module rst_hold_counter (
  input  wire  axis_aclk,
  input  wire  axis_rst,
  output logic pipe_rst
);

  localparam int HOLD  = `SHELL_RST_HOLD;
  localparam int CNT_W = $clog2(HOLD + 1);

  logic [CNT_W-1:0] hold_cnt;

  // saturates at HOLD, restarts on every axis_rst
  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      hold_cnt <= '0;
    end else if (hold_cnt != CNT_W'(HOLD)) begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // high from the first reset edge until the count saturates
  assign pipe_rst = (hold_cnt != CNT_W'(HOLD));

endmodule

`default_nettype wire

//--- hdl/h2c_arbiter.sv
/*
 * Merges the two host-to-card queues onto one pipeline stream. A queue
 * keeps the grant for a whole packet; its metadata gets the source code.
 */
`timescale 1ns/1ps
`default_nettype none

`include "shell_defines.svh"

module h2c_arbiter (
  input  wire                     axis_aclk,
  input  wire                     pipe_rst,
  input  shell_pkg::axis_beat_t   h2c_0_beat,
  input  wire                     h2c_0_valid,
  output logic                    h2c_0_ready,
  input  shell_pkg::axis_beat_t   h2c_1_beat,
  input  wire                     h2c_1_valid,
  output logic                    h2c_1_ready,
  output shell_pkg::axis_beat_t   merged_beat,
  output logic                    merged_valid,
  input  wire                     merged_ready
);

  import shell_pkg::*;

  // one-hot, bit 0 for queue 0
  logic [1:0] grant_q;
  logic [1:0] grant;
  axis_beat_t src_beat;
  logic       xfer;

  // held grant wins, else queue 0 has priority
  always_comb begin
    if (grant_q != 2'b00) begin
      grant = grant_q;
    end else if (h2c_0_valid) begin
      grant = 2'b01;
    end else if (h2c_1_valid) begin
      grant = 2'b10;
    end else begin
      grant = 2'b00;
    end
  end

  assign merged_valid = !pipe_rst &&
                        ((grant[0] && h2c_0_valid) || (grant[1] && h2c_1_valid));
  assign h2c_0_ready  = !pipe_rst && grant[0] && merged_ready;
  assign h2c_1_ready  = !pipe_rst && grant[1] && merged_ready;
  assign xfer         = merged_valid && merged_ready;

  assign src_beat = grant[1] ? h2c_1_beat : h2c_0_beat;

  // payload passes, metadata is rebuilt
  always_comb begin
    merged_beat            = src_beat;
    merged_beat.tuser      = '0;
    merged_beat.tuser.size = src_beat.tuser.size;
    merged_beat.tuser.src.code = grant[1] ? `SHELL_PORT_QDMA1 : `SHELL_PORT_QDMA0;
    merged_beat.tuser.dst.code = 8'h00;
  end

  // grant drops on the edge that takes tlast
  always_ff @(posedge axis_aclk) begin
    if (pipe_rst) begin
      grant_q <= 2'b00;
    end else if (xfer) begin
      if (src_beat.tlast) begin
        grant_q <= 2'b00;
      end else begin
        grant_q <= grant;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/c2h_pkt_fsm.sv
/*
 * Follows packet boundaries on the card-to-host stream and strobes
 * first_beat on the beat that opens each packet, for the demux.
 */
`timescale 1ns/1ps
`default_nettype none

module c2h_pkt_fsm (
  input  wire                    axis_aclk,
  input  wire                    pipe_rst,
  input  wire                    in_valid,
  input  wire                    in_ready,
  input  wire                    in_last,
  output logic                   first_beat,
  output shell_pkg::c2h_state_e  state
);

  import shell_pkg::*;

  logic xfer;

  assign xfer = in_valid && in_ready;

  // a beat taken while idle opens a packet, even a one-beat one
  assign first_beat = xfer && (state == IDLE);

  always_ff @(posedge axis_aclk) begin
    if (pipe_rst) begin
      state <= IDLE;
    end else if (xfer) begin
      if (in_last) begin
        state <= IDLE;
      end else begin
        state <= PKT;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/c2h_demux.sv
/*
 * Steers card-to-host beats to the host queues by the destination flags.
 * Size and destination code are taken on a first beat and held per queue.
 */
`timescale 1ns/1ps
`default_nettype none

module c2h_demux (
  input  wire                    axis_aclk,
  input  wire                    pipe_rst,
  input  wire                    first_beat,
  input  shell_pkg::axis_beat_t  in_beat,
  input  wire                    in_valid,
  output logic                   in_ready,
  output shell_pkg::axis_beat_t  c2h_0_beat,
  output logic                   c2h_0_valid,
  input  wire                    c2h_0_ready,
  output logic [15:0]            c2h_0_size,
  output shell_pkg::qdma_dst_e   c2h_0_dst,
  output shell_pkg::axis_beat_t  c2h_1_beat,
  output logic                   c2h_1_valid,
  input  wire                    c2h_1_ready,
  output logic [15:0]            c2h_1_size,
  output shell_pkg::qdma_dst_e   c2h_1_dst
);

  import shell_pkg::*;

  logic [1:0]  q_hit;
  logic [1:0]  q_load;
  logic [15:0] size_q   [2];
  qdma_dst_e   dst_q    [2];
  logic [15:0] size_out [2];
  qdma_dst_e   dst_out  [2];

  // flags view of the dst byte
  assign q_hit  = {in_beat.tuser.dst.flags.qdma1, in_beat.tuser.dst.flags.qdma0};
  assign q_load = first_beat ? q_hit : 2'b00;

  // a beat flagged for both queues waits for both
  assign in_ready    = !pipe_rst && c2h_0_ready && c2h_1_ready;
  assign c2h_0_valid = !pipe_rst && in_valid && q_hit[0];
  assign c2h_1_valid = !pipe_rst && in_valid && q_hit[1];
  assign c2h_0_beat  = in_beat;
  assign c2h_1_beat  = in_beat;

  for (genvar k = 0; k < 2; k++) begin : g_queue
    localparam qdma_dst_e QCODE = (k == 0) ? QDMA_DST_Q0 : QDMA_DST_Q1;

    always_ff @(posedge axis_aclk) begin
      if (q_load[k]) begin
        size_q[k] <= in_beat.tuser.size;
        dst_q[k]  <= QCODE;
      end
    end

    // on the first beat show the new values straight away
    assign size_out[k] = q_load[k] ? in_beat.tuser.size : size_q[k];
    assign dst_out[k]  = q_load[k] ? QCODE : dst_q[k];
  end

  assign c2h_0_size = size_out[0];
  assign c2h_1_size = size_out[1];
  assign c2h_0_dst  = dst_out[0];
  assign c2h_1_dst  = dst_out[1];

endmodule

`default_nettype wire

//--- hdl/dma_attach_top.sv
/*
 * Host DMA attachment: merges two h2c queues into the pipeline and
 * fans the pipeline output out to two c2h queues, after a reset hold.
 */
`timescale 1ns/1ps
`default_nettype none

module dma_attach_top (
  input  wire                    axis_aclk,
  input  wire                    axis_rst,

  // host to card
  input  shell_pkg::axis_beat_t  h2c_0_beat,
  input  wire                    h2c_0_valid,
  output logic                   h2c_0_ready,
  input  shell_pkg::axis_beat_t  h2c_1_beat,
  input  wire                    h2c_1_valid,
  output logic                   h2c_1_ready,

  // merged stream into the pipeline
  output shell_pkg::axis_beat_t  pipe_in_beat,
  output logic                   pipe_in_valid,
  input  wire                    pipe_in_ready,

  // pipeline output toward the host
  input  shell_pkg::axis_beat_t  pipe_out_beat,
  input  wire                    pipe_out_valid,
  output logic                   pipe_out_ready,

  // card to host
  output shell_pkg::axis_beat_t  c2h_0_beat,
  output logic                   c2h_0_valid,
  input  wire                    c2h_0_ready,
  output logic [15:0]            c2h_0_size,
  output shell_pkg::qdma_dst_e   c2h_0_dst,
  output shell_pkg::axis_beat_t  c2h_1_beat,
  output logic                   c2h_1_valid,
  input  wire                    c2h_1_ready,
  output logic [15:0]            c2h_1_size,
  output shell_pkg::qdma_dst_e   c2h_1_dst
);

  logic pipe_rst;
  logic first_beat;

  rst_hold_counter u_rst_hold (
    .axis_aclk (axis_aclk),
    .axis_rst  (axis_rst),
    .pipe_rst  (pipe_rst)
  );

  h2c_arbiter u_h2c_arb (
    .axis_aclk    (axis_aclk),
    .pipe_rst     (pipe_rst),
    .h2c_0_beat   (h2c_0_beat),
    .h2c_0_valid  (h2c_0_valid),
    .h2c_0_ready  (h2c_0_ready),
    .h2c_1_beat   (h2c_1_beat),
    .h2c_1_valid  (h2c_1_valid),
    .h2c_1_ready  (h2c_1_ready),
    .merged_beat  (pipe_in_beat),
    .merged_valid (pipe_in_valid),
    .merged_ready (pipe_in_ready)
  );

  // state is only watched from inside the FSM
  c2h_pkt_fsm u_c2h_fsm (
    .axis_aclk  (axis_aclk),
    .pipe_rst   (pipe_rst),
    .in_valid   (pipe_out_valid),
    .in_ready   (pipe_out_ready),
    .in_last    (pipe_out_beat.tlast),
    .first_beat (first_beat),
    .state      ()
  );

  c2h_demux u_c2h_demux (
    .axis_aclk   (axis_aclk),
    .pipe_rst    (pipe_rst),
    .first_beat  (first_beat),
    .in_beat     (pipe_out_beat),
    .in_valid    (pipe_out_valid),
    .in_ready    (pipe_out_ready),
    .c2h_0_beat  (c2h_0_beat),
    .c2h_0_valid (c2h_0_valid),
    .c2h_0_ready (c2h_0_ready),
    .c2h_0_size  (c2h_0_size),
    .c2h_0_dst   (c2h_0_dst),
    .c2h_1_beat  (c2h_1_beat),
    .c2h_1_valid (c2h_1_valid),
    .c2h_1_ready (c2h_1_ready),
    .c2h_1_size  (c2h_1_size),
    .c2h_1_dst   (c2h_1_dst)
  );

endmodule

`default_nettype wire

//--- bench/dma_attach_assert.sv
/*
 * Concurrent checks on a stream handshake and its packet tracking.
 * Bound into the h2c arbiter and the c2h packet FSM.
 */
`timescale 1ns/1ps
`default_nettype none

module dma_attach_assert (
  input wire                    axis_aclk,
  input wire                    pipe_rst,
  input wire                    valid,
  input wire                    ready,
  input wire                    last,
  input wire [63:0]             data,
  input wire [1:0]              grant,
  input shell_pkg::c2h_state_e  state
);

  import shell_pkg::*;

  int fail_count = 0;

  // a stalled beat must stay put
  a_valid_hold: assert property (@(posedge axis_aclk) disable iff (pipe_rst !== 1'b0)
    valid && !ready |=> valid)
    else begin
      fail_count++;
      $error("stream valid dropped before its transfer");
    end

  a_data_hold: assert property (@(posedge axis_aclk) disable iff (pipe_rst !== 1'b0)
    valid && !ready |=> $stable(data))
    else begin
      fail_count++;
      $error("stream data changed while stalled");
    end

  a_grant_onehot: assert property (@(posedge axis_aclk) disable iff (pipe_rst !== 1'b0)
    $onehot0(grant))
    else begin
      fail_count++;
      $error("more than one h2c queue holds the grant");
    end

  // packet closes on the accepted tlast
  a_pkt_end: assert property (@(posedge axis_aclk) disable iff (pipe_rst !== 1'b0)
    valid && ready && last |=> (grant == 2'b00) && (state == IDLE))
    else begin
      fail_count++;
      $error("packet still open after an accepted tlast");
    end

endmodule

`default_nettype wire

//--- bench/tb_clkgen.sv
/*
 * Testbench clock and reset source: axis_aclk at 100 ns and axis_rst
 * held high for the first 4 cycles, released on a falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic axis_aclk,
  output logic axis_rst
);

  initial begin
    axis_aclk = 1'b0;
    forever #50 axis_aclk = ~axis_aclk;
  end

  initial begin
    axis_rst = 1'b1;
    repeat (4) @(posedge axis_aclk);
    @(negedge axis_aclk);
    axis_rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/tb_checker.sv
/*
 * Watches the DUT ports and compares every transfer with the beats the
 * testbench expects. Also checks the reset hold and c2h ready merge.
 */
`timescale 1ns/1ps
`default_nettype none

`include "shell_defines.svh"

module tb_checker (
  input wire                    axis_aclk,
  input wire                    axis_rst,
  input wire                    h2c_0_ready,
  input wire                    h2c_1_ready,
  input shell_pkg::axis_beat_t  pipe_in_beat,
  input wire                    pipe_in_valid,
  input wire                    pipe_in_ready,
  input wire                    pipe_out_ready,
  input shell_pkg::axis_beat_t  c2h_0_beat,
  input wire                    c2h_0_valid,
  input wire                    c2h_0_ready,
  input wire [15:0]             c2h_0_size,
  input wire [15:0]             c2h_0_dst,
  input shell_pkg::axis_beat_t  c2h_1_beat,
  input wire                    c2h_1_valid,
  input wire                    c2h_1_ready,
  input wire [15:0]             c2h_1_size,
  input wire [15:0]             c2h_1_dst
);

  import shell_pkg::*;

  typedef struct packed {
    axis_beat_t  beat;
    logic [15:0] size;
    logic [15:0] dst;
  } c2h_exp_t;

  int         errors = 0;
  int         hold_cycles = 0;
  string      test_name = "reset hold";
  axis_beat_t exp_pipe[$];
  c2h_exp_t   exp_c2h[2][$];

  task automatic push_pipe(input axis_beat_t beat);
    exp_pipe.push_back(beat);
  endtask

  task automatic push_c2h(input int k, input axis_beat_t beat, input logic [15:0] size,
                          input logic [15:0] dst);
    c2h_exp_t e;
    e.beat = beat;
    e.size = size;
    e.dst  = dst;
    exp_c2h[k].push_back(e);
  endtask

  function automatic int pending();
    return exp_pipe.size() + exp_c2h[0].size() + exp_c2h[1].size();
  endfunction

  task automatic compare(input string what, input logic [255:0] exp, input logic [255:0] act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_c2h(input int k, input axis_beat_t beat, input logic valid,
                           input logic ready, input logic [15:0] size, input logic [15:0] dst);
    c2h_exp_t e;
    // a queue beat counts only once the pipeline stream takes it
    if (valid && ready && pipe_out_ready) begin
      if (exp_c2h[k].size() == 0) begin
        errors++;
        $display("%s: c2h queue %0d delivered a beat nobody sent to it", test_name, k);
      end else begin
        e = exp_c2h[k].pop_front();
        compare($sformatf("c2h_%0d beat", k), e.beat, beat);
        compare($sformatf("c2h_%0d size", k), e.size, size);
        compare($sformatf("c2h_%0d dst", k), e.dst, dst);
      end
    end
  endtask

  always @(posedge axis_aclk) begin
    if (axis_rst) begin
      hold_cycles = 0;
    end else if (hold_cycles < `SHELL_RST_HOLD) begin
      if ({h2c_0_ready, h2c_1_ready, pipe_in_valid, pipe_out_ready,
           c2h_0_valid, c2h_1_valid} !== 6'b0) begin
        errors++;
        $display("reset hold: a valid or ready output was high %0d cycles after reset",
                 hold_cycles);
      end
      hold_cycles++;
    end else begin
      if (pipe_out_ready !== (c2h_0_ready && c2h_1_ready)) begin
        errors++;
        $display("%s: pipe_out ready does not follow both c2h readies", test_name);
      end
      if (pipe_in_valid && pipe_in_ready) begin
        if (exp_pipe.size() == 0) begin
          errors++;
          $display("%s: pipe_in carried a beat that no queue sent", test_name);
        end else begin
          compare("pipe_in beat", exp_pipe.pop_front(), pipe_in_beat);
        end
      end
      check_c2h(0, c2h_0_beat, c2h_0_valid, c2h_0_ready, c2h_0_size, c2h_0_dst);
      check_c2h(1, c2h_1_beat, c2h_1_valid, c2h_1_ready, c2h_1_size, c2h_1_dst);
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_dma_attach.sv
/*
 * Testbench top for the host DMA attachment. Applies a table of h2c and
 * c2h packets with optional back-pressure and prints the verdict.
 */
`timescale 1ns/1ps
`default_nettype none

`include "shell_defines.svh"

module tb_dma_attach;

  import shell_pkg::*;

  typedef enum int {H2C_Q0, H2C_Q1, H2C_BOTH, H2C_Q1_LEAD, C2H} row_kind_e;

  typedef struct {
    string       name;
    row_kind_e   kind;
    int          beats;
    logic [15:0] size;
    logic [7:0]  flags;
    int          stall;
  } row_t;

  wire        axis_aclk;
  wire        axis_rst;
  axis_beat_t h2c_0_beat, h2c_1_beat, pipe_in_beat, pipe_out_beat;
  axis_beat_t c2h_0_beat, c2h_1_beat;
  logic       h2c_0_valid, h2c_1_valid, h2c_0_ready, h2c_1_ready;
  logic       pipe_in_valid, pipe_in_ready, pipe_out_valid, pipe_out_ready;
  logic       c2h_0_valid, c2h_1_valid, c2h_0_ready, c2h_1_ready;
  logic [15:0] c2h_0_size, c2h_1_size;
  qdma_dst_e  c2h_0_dst, c2h_1_dst;

  row_t rows[$];
  int   stall_level = 0;
  int   cycles = 0;
  int   cycle_limit = 0;

  tb_clkgen u_clkgen (.axis_aclk(axis_aclk), .axis_rst(axis_rst));

  dma_attach_top UUT (
    .axis_aclk(axis_aclk), .axis_rst(axis_rst),
    .h2c_0_beat(h2c_0_beat), .h2c_0_valid(h2c_0_valid), .h2c_0_ready(h2c_0_ready),
    .h2c_1_beat(h2c_1_beat), .h2c_1_valid(h2c_1_valid), .h2c_1_ready(h2c_1_ready),
    .pipe_in_beat(pipe_in_beat), .pipe_in_valid(pipe_in_valid),
    .pipe_in_ready(pipe_in_ready),
    .pipe_out_beat(pipe_out_beat), .pipe_out_valid(pipe_out_valid),
    .pipe_out_ready(pipe_out_ready),
    .c2h_0_beat(c2h_0_beat), .c2h_0_valid(c2h_0_valid), .c2h_0_ready(c2h_0_ready),
    .c2h_0_size(c2h_0_size), .c2h_0_dst(c2h_0_dst),
    .c2h_1_beat(c2h_1_beat), .c2h_1_valid(c2h_1_valid), .c2h_1_ready(c2h_1_ready),
    .c2h_1_size(c2h_1_size), .c2h_1_dst(c2h_1_dst)
  );

  tb_checker chk (
    .axis_aclk(axis_aclk), .axis_rst(axis_rst),
    .h2c_0_ready(h2c_0_ready), .h2c_1_ready(h2c_1_ready),
    .pipe_in_beat(pipe_in_beat), .pipe_in_valid(pipe_in_valid),
    .pipe_in_ready(pipe_in_ready), .pipe_out_ready(pipe_out_ready),
    .c2h_0_beat(c2h_0_beat), .c2h_0_valid(c2h_0_valid), .c2h_0_ready(c2h_0_ready),
    .c2h_0_size(c2h_0_size), .c2h_0_dst(c2h_0_dst),
    .c2h_1_beat(c2h_1_beat), .c2h_1_valid(c2h_1_valid), .c2h_1_ready(c2h_1_ready),
    .c2h_1_size(c2h_1_size), .c2h_1_dst(c2h_1_dst)
  );

  bind h2c_arbiter dma_attach_assert u_arb_sva (
    .axis_aclk(axis_aclk), .pipe_rst(pipe_rst), .valid(merged_valid),
    .ready(merged_ready), .last(merged_beat.tlast), .data(merged_beat.tdata),
    .grant(grant_q), .state(shell_pkg::IDLE)
  );

  bind c2h_pkt_fsm dma_attach_assert u_fsm_sva (
    .axis_aclk(axis_aclk), .pipe_rst(pipe_rst), .valid(in_valid),
    .ready(in_ready), .last(in_last), .data(64'd0), .grant(2'b00), .state(state)
  );

  // sink readies, stalled one cycle in four when the row asks for it
  always @(negedge axis_aclk) begin
    pipe_in_ready <= (stall_level == 0) || ($urandom % 4 != 0);
    c2h_0_ready   <= (stall_level == 0) || ($urandom % 4 != 0);
    c2h_1_ready   <= (stall_level == 0) || ($urandom % 4 != 0);
  end

  always @(posedge axis_aclk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic add_row(input string name, input row_kind_e kind, input int beats,
                         input logic [15:0] size, input logic [7:0] flags, input int stall);
    row_t r;
    r.name  = name;
    r.kind  = kind;
    r.beats = beats;
    r.size  = size;
    r.flags = flags;
    r.stall = stall;
    rows.push_back(r);
  endtask

  function automatic axis_beat_t random_beat(input logic last);
    axis_beat_t b;
    b.tdata = {$urandom, $urandom};
    b.tkeep = last ? 8'($urandom | 1) : 8'hff;
    b.tlast = last;
    b.tuser = {$urandom, $urandom, $urandom, $urandom};
    return b;
  endfunction

  // host packet plus the beat the merged stream should show for it
  task automatic make_h2c(input int q, input row_t r, output axis_beat_t pkt[$]);
    axis_beat_t b;
    axis_beat_t e;
    pkt.delete();
    for (int i = 0; i < r.beats; i++) begin
      b = random_beat(i == r.beats - 1);
      b.tuser.size = r.size;
      pkt.push_back(b);
      e = b;
      e.tuser = '0;
      e.tuser.size = r.size;
      e.tuser.src.code = (q == 0) ? `SHELL_PORT_QDMA0 : `SHELL_PORT_QDMA1;
      chk.push_pipe(e);
    end
  endtask

  task automatic drive_h2c(input int q, input axis_beat_t pkt[$]);
    foreach (pkt[i]) begin
      @(negedge axis_aclk);
      if (q == 0) begin
        h2c_0_beat  = pkt[i];
        h2c_0_valid = 1'b1;
      end else begin
        h2c_1_beat  = pkt[i];
        h2c_1_valid = 1'b1;
      end
      do @(posedge axis_aclk); while (!((q == 0) ? h2c_0_ready : h2c_1_ready));
    end
    @(negedge axis_aclk);
    if (q == 0) h2c_0_valid = 1'b0;
    else h2c_1_valid = 1'b0;
  endtask

  // later beats carry a junk size, the queues must keep the first one
  task automatic send_c2h(input row_t r);
    axis_beat_t b;
    for (int i = 0; i < r.beats; i++) begin
      b = random_beat(i == r.beats - 1);
      b.tuser.dst.code = r.flags;
      if (i == 0) b.tuser.size = r.size;
      if (r.flags[1]) chk.push_c2h(0, b, r.size, 16'd1);
      if (r.flags[3]) chk.push_c2h(1, b, r.size, 16'd2);
      @(negedge axis_aclk);
      pipe_out_beat  = b;
      pipe_out_valid = 1'b1;
      do @(posedge axis_aclk); while (!pipe_out_ready);
    end
    @(negedge axis_aclk);
    pipe_out_valid = 1'b0;
  endtask

  initial begin
    int         seed;
    int         total_beats;
    int         sva_fails;
    axis_beat_t p0[$];
    axis_beat_t p1[$];

    seed = $urandom(94833);
    pipe_in_ready  = 1'b0;
    c2h_0_ready    = 1'b0;
    c2h_1_ready    = 1'b0;
    // valid inputs during the hold must not leak through
    h2c_0_beat     = random_beat(1'b1);
    h2c_1_beat     = random_beat(1'b1);
    pipe_out_beat  = random_beat(1'b1);
    h2c_0_valid    = 1'b1;
    h2c_1_valid    = 1'b1;
    pipe_out_valid = 1'b1;

    add_row("h2c q0 single", H2C_Q0, 1, 16'd64, 8'h00, 0);
    add_row("h2c q1 burst", H2C_Q1, 4, 16'd256, 8'h00, 0);
    add_row("h2c q0 stalled", H2C_Q0, 5, 16'd300, 8'h00, 1);
    add_row("h2c both queues", H2C_BOTH, 3, 16'd200, 8'h00, 0);
    add_row("h2c q1 holds grant", H2C_Q1_LEAD, 3, 16'd180, 8'h00, 0);
    add_row("h2c both stalled", H2C_BOTH, 4, 16'd120, 8'h00, 1);
    add_row("c2h qdma0", C2H, 3, 16'd96, 8'h02, 0);
    add_row("c2h qdma1", C2H, 4, 16'd500, 8'h08, 0);
    add_row("c2h both queues", C2H, 3, 16'd72, 8'h0a, 0);
    add_row("c2h qdma0 single", C2H, 1, 16'd8, 8'h02, 0);
    add_row("c2h both stalled", C2H, 5, 16'd640, 8'h0a, 1);
    add_row("c2h qdma1 stalled", C2H, 4, 16'd1000, 8'h08, 1);

    total_beats = 0;
    foreach (rows[i]) begin
      if (rows[i].kind == H2C_BOTH || rows[i].kind == H2C_Q1_LEAD) begin
        total_beats += 2 * rows[i].beats;
      end else begin
        total_beats += rows[i].beats;
      end
    end
    cycle_limit = total_beats * 4 + 100;

    @(negedge axis_rst);
    repeat (`SHELL_RST_HOLD - 2) @(negedge axis_aclk);
    h2c_0_valid    = 1'b0;
    h2c_1_valid    = 1'b0;
    pipe_out_valid = 1'b0;
    repeat (3) @(negedge axis_aclk);

    foreach (rows[i]) begin
      chk.test_name = rows[i].name;
      stall_level   = rows[i].stall;
      case (rows[i].kind)
        H2C_Q0: begin
          make_h2c(0, rows[i], p0);
          drive_h2c(0, p0);
        end
        H2C_Q1: begin
          make_h2c(1, rows[i], p1);
          drive_h2c(1, p1);
        end
        H2C_BOTH: begin
          // queue 0 wins, its whole packet goes first
          make_h2c(0, rows[i], p0);
          make_h2c(1, rows[i], p1);
          fork
            drive_h2c(0, p0);
            drive_h2c(1, p1);
          join
        end
        H2C_Q1_LEAD: begin
          // queue 0 turns valid one beat into the queue 1 packet and has to wait
          make_h2c(1, rows[i], p1);
          make_h2c(0, rows[i], p0);
          fork
            drive_h2c(1, p1);
            begin
              @(negedge axis_aclk);
              drive_h2c(0, p0);
            end
          join
        end
        default: send_c2h(rows[i]);
      endcase
      @(negedge axis_aclk);
    end

    stall_level = 0;
    repeat (2) @(negedge axis_aclk);
    sva_fails = UUT.u_h2c_arb.u_arb_sva.fail_count + UUT.u_c2h_fsm.u_fsm_sva.fail_count;
    $display("errors: %0d value checks, %0d beats missing, %0d assertions",
             chk.errors, chk.pending(), sva_fails);
    if (chk.errors == 0 && chk.pending() == 0 && sva_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/shell_pkg.sv
hdl/rst_hold_counter.sv
hdl/h2c_arbiter.sv
hdl/c2h_pkt_fsm.sv
hdl/c2h_demux.sv
hdl/dma_attach_top.sv
bench/dma_attach_assert.sv
bench/tb_clkgen.sv
bench/tb_checker.sv
bench/tb_dma_attach.sv

//--- Bender.yml
package:
  name: dma_attach

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/shell_pkg.sv
      - hdl/rst_hold_counter.sv
      - hdl/h2c_arbiter.sv
      - hdl/c2h_pkt_fsm.sv
      - hdl/c2h_demux.sv
      - hdl/dma_attach_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/dma_attach_assert.sv
      - bench/tb_clkgen.sv
      - bench/tb_checker.sv
      - bench/tb_dma_attach.sv
